/* rv_core.f */
hw/rv_core_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_bus_unit.sv
hw/rv_control.sv
hw/rv_core.sv
bench/rv_core_props.sv
bench/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - hw/rv_core_pkg.sv
  - hw/rv_decoder.sv
  - hw/rv_regfile.sv
  - hw/rv_alu.sv
  - hw/rv_bus_unit.sv
  - hw/rv_control.sv
  - hw/rv_core.sv
  - target: test
    files:
      - bench/rv_core_props.sv
      - bench/rv_core_tb.sv

/* bench/rv_core_tb.sv */
module rv_core_tb;
    import rv_core_pkg::*;

    localparam int    max_cycles = 8000;
    localparam word_t done_addr  = 32'h0000_03F0;

    logic       clk_in;
    logic       reset_in;
    word_t      paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    word_t      pwdata;
    logic [3:0] pstrb;
    word_t      prdata;
    logic       pready;

    word_t mem [256];
    int    prog_addr;
    int    wait_left;
    int    idx;
    logic  done_seen;

    rv_core u_dut (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .prdata   (prdata),
        .pready   (pready)
    );

    initial clk_in = 1'b0;
    always #5 clk_in = !clk_in;

    // Instruction encoders
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
    endfunction

    function automatic word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                     input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t s_type(input logic [2:0] f3, input int rs2, input int rs1,
                                     input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), f3, i[4:0], 7'h23};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int imm);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'h63};
    endfunction

    function automatic word_t j_type(input int rd, input int imm);
        logic [20:0] i;
        i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'h6F};
    endfunction

    task automatic emit(input word_t w);
        mem[prog_addr >> 2] = w;
        prog_addr += 4;
    endtask

    // Taken branch skips a corrupting add, the untaken one runs a signature add
    task automatic branch_pair(input logic [2:0] f3, input int t1, input int t2,
                               input int n1, input int n2, input int sig_bit);
        emit(b_type(f3, t1, t2, 8));
        emit(i_type(7'h13, 3'b000, 5, 5, 12'h100));
        emit(b_type(f3, n1, n2, 8));
        emit(i_type(7'h13, 3'b000, 5, 5, sig_bit));
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5EED_0000 | i;
        end
        mem[32'h300 >> 2] = 32'h8A7F_F581;
        prog_addr = 0;
        emit(i_type(7'h13, 3'b000, 31, 0, 12'h200));
        emit(i_type(7'h13, 3'b000, 1, 0, 100));
        emit(i_type(7'h13, 3'b000, 2, 0, -7));
        emit(r_type(7'h00, 3'b000, 3, 1, 2));
        emit(s_type(3'b010, 3, 31, 0));
        emit(r_type(7'h20, 3'b000, 3, 1, 2));
        emit(s_type(3'b010, 3, 31, 4));
        emit(i_type(7'h13, 3'b000, 4, 0, 5));
        emit(r_type(7'h00, 3'b001, 3, 2, 4));
        emit(s_type(3'b010, 3, 31, 8));
        emit(r_type(7'h00, 3'b010, 3, 2, 1));
        emit(s_type(3'b010, 3, 31, 12));
        emit(r_type(7'h00, 3'b011, 3, 2, 1));
        emit(s_type(3'b010, 3, 31, 16));
        emit(r_type(7'h00, 3'b100, 3, 1, 2));
        emit(s_type(3'b010, 3, 31, 20));
        emit(r_type(7'h00, 3'b101, 3, 2, 4));
        emit(s_type(3'b010, 3, 31, 24));
        emit(r_type(7'h20, 3'b101, 3, 2, 4));
        emit(s_type(3'b010, 3, 31, 28));
        emit(r_type(7'h00, 3'b110, 3, 1, 2));
        emit(s_type(3'b010, 3, 31, 32));
        emit(r_type(7'h00, 3'b111, 3, 1, 2));
        emit(s_type(3'b010, 3, 31, 36));
        emit(i_type(7'h13, 3'b000, 3, 1, -300));
        emit(s_type(3'b010, 3, 31, 40));
        emit(i_type(7'h13, 3'b101, 3, 2, 12'h402));
        emit(s_type(3'b010, 3, 31, 44));
        branch_pair(3'b000, 1, 1, 1, 2, 1);
        branch_pair(3'b001, 1, 2, 1, 1, 2);
        branch_pair(3'b100, 2, 1, 1, 2, 4);
        branch_pair(3'b101, 1, 2, 2, 1, 8);
        branch_pair(3'b110, 1, 2, 2, 1, 16);
        branch_pair(3'b111, 2, 1, 1, 2, 32);
        emit(s_type(3'b010, 5, 31, 48));
        emit(j_type(6, 8));
        emit(i_type(7'h13, 3'b000, 5, 5, 1));
        emit(s_type(3'b010, 6, 31, 52));
        emit(i_type(7'h13, 3'b000, 7, 0, 12'h0F0));
        // Target 0xF1 has bit 0 cleared by jalr
        emit(i_type(7'h67, 3'b000, 8, 7, 1));
        emit(i_type(7'h13, 3'b000, 8, 0, 0));
        emit(i_type(7'h13, 3'b000, 8, 0, 0));
        emit(s_type(3'b010, 8, 31, 56));
        emit({20'hABCDE, 5'd9, 7'h37});
        emit(s_type(3'b010, 9, 31, 60));
        emit({20'h12345, 5'd10, 7'h17});
        emit(s_type(3'b010, 10, 31, 64));
        emit(i_type(7'h13, 3'b000, 0, 0, 55));
        emit(s_type(3'b010, 0, 31, 68));
        emit(i_type(7'h13, 3'b000, 11, 0, 12'h300));
        emit(i_type(7'h03, 3'b000, 12, 11, 1));
        emit(s_type(3'b010, 12, 31, 72));
        emit(i_type(7'h03, 3'b100, 12, 11, 1));
        emit(s_type(3'b010, 12, 31, 76));
        emit(i_type(7'h03, 3'b001, 12, 11, 2));
        emit(s_type(3'b010, 12, 31, 80));
        emit(i_type(7'h03, 3'b101, 12, 11, 0));
        emit(s_type(3'b010, 12, 31, 84));
        emit(i_type(7'h03, 3'b000, 12, 11, 3));
        emit(s_type(3'b010, 12, 31, 88));
        emit(i_type(7'h13, 3'b000, 13, 0, 12'h05A));
        emit(s_type(3'b000, 13, 31, 92));
        emit(s_type(3'b000, 13, 31, 97));
        emit(s_type(3'b000, 13, 31, 102));
        emit(s_type(3'b000, 13, 31, 107));
        emit(s_type(3'b001, 2, 31, 108));
        emit(s_type(3'b001, 2, 31, 114));
        emit(s_type(3'b010, 1, 31, 496));
        emit(j_type(0, 0));
    endtask

    // APB memory with 0 to 3 wait states per transfer
    always @(posedge clk_in) begin
        #1;
        pready = 1'b0;
        if (psel && !penable) begin
            wait_left = $urandom_range(3, 0);
        end else if (psel && penable) begin
            if (wait_left == 0) begin
                idx    = int'(paddr[9:2]);
                pready = 1'b1;
                prdata = mem[idx];
                if (pwrite) begin
                    for (int b = 0; b < 4; b++) begin
                        if (pstrb[b]) begin
                            mem[idx][8*b +: 8] = pwdata[8*b +: 8];
                        end
                    end
                    if (paddr == done_addr) begin
                        done_seen = 1'b1;
                    end
                end
            end else begin
                wait_left--;
            end
        end
    end

    task automatic report_failure();
        if (u_dut.u_props.err_is_value) begin
            $display("[FAIL] %s: expected %h, actual %h", u_dut.u_props.err_name,
                     u_dut.u_props.err_exp, u_dut.u_props.err_act);
        end else begin
            $display("Protocol check failed: %s", u_dut.u_props.err_name);
        end
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    initial begin
        int cycles;
        reset_in  = 1'b0;
        pready    = 1'b0;
        prdata    = '0;
        done_seen = 1'b0;
        wait_left = 0;
        void'($urandom(85));
        load_program();
        repeat (3) @(posedge clk_in);
        #1;
        reset_in = 1'b1;
        cycles = 0;
        while (!done_seen && !u_dut.u_props.error_seen && cycles < max_cycles) begin
            @(posedge clk_in);
            #2;
            cycles++;
        end
        // One more edge so the done store's own check has run
        if (done_seen && !u_dut.u_props.error_seen) begin
            @(posedge clk_in);
            #2;
        end
        if (u_dut.u_props.error_seen) begin
            report_failure();
        end else if (!done_seen) begin
            $display("Timeout: the program never finished within %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* bench/rv_core_props.sv */
module rv_core_props
    import rv_core_pkg::*;
(
    input logic       clk_in,
    input logic       reset_in,
    input word_t      paddr,
    input logic       psel,
    input logic       penable,
    input logic       pwrite,
    input word_t      pwdata,
    input logic [3:0] pstrb,
    input logic       pready
);

    localparam word_t result_base = 32'h0000_0200;
    localparam word_t done_addr   = 32'h0000_03F0;
    localparam int    n_results   = 29;

    word_t                exp_data [n_results];
    logic [3:0]           exp_strb [n_results];
    string                names [n_results];
    logic [n_results-1:0] written;
    logic                 wr_done;
    logic                 result_wr;
    int                   slot;

    // Read by the testbench top after an assertion fails
    logic  error_seen;
    logic  err_is_value;
    string err_name;
    word_t err_exp;
    word_t err_act;

    task automatic record(input string name, input word_t e, input word_t a, input logic v);
        if (!error_seen) begin
            err_name     = name;
            err_exp      = e;
            err_act      = a;
            err_is_value = v;
        end
        error_seen = 1'b1;
    endtask

    task automatic expect_slot(input int i, input string name, input word_t d,
                               input logic [3:0] s);
        names[i]    = name;
        exp_data[i] = d;
        exp_strb[i] = s;
    endtask

    // Expected signature of the test program
    initial begin
        error_seen = 1'b0;
        expect_slot(0, "add", 32'h0000_005D, 4'hF);
        expect_slot(1, "sub", 32'h0000_006B, 4'hF);
        expect_slot(2, "sll", 32'hFFFF_FF20, 4'hF);
        expect_slot(3, "slt", 32'h0000_0001, 4'hF);
        expect_slot(4, "sltu", 32'h0000_0000, 4'hF);
        expect_slot(5, "xor", 32'hFFFF_FF9D, 4'hF);
        expect_slot(6, "srl", 32'h07FF_FFFF, 4'hF);
        expect_slot(7, "sra", 32'hFFFF_FFFF, 4'hF);
        expect_slot(8, "or", 32'hFFFF_FFFD, 4'hF);
        expect_slot(9, "and", 32'h0000_0060, 4'hF);
        expect_slot(10, "addi negative", 32'hFFFF_FF38, 4'hF);
        expect_slot(11, "srai", 32'hFFFF_FFFE, 4'hF);
        expect_slot(12, "branch signature", 32'h0000_003F, 4'hF);
        expect_slot(13, "jal link", 32'h0000_00D8, 4'hF);
        expect_slot(14, "jalr link", 32'h0000_00E8, 4'hF);
        expect_slot(15, "lui", 32'hABCD_E000, 4'hF);
        expect_slot(16, "auipc", 32'h1234_50FC, 4'hF);
        expect_slot(17, "x0 write", 32'h0000_0000, 4'hF);
        expect_slot(18, "lb lane 1", 32'hFFFF_FFF5, 4'hF);
        expect_slot(19, "lbu lane 1", 32'h0000_00F5, 4'hF);
        expect_slot(20, "lh upper", 32'hFFFF_8A7F, 4'hF);
        expect_slot(21, "lhu lower", 32'h0000_F581, 4'hF);
        expect_slot(22, "lb lane 3", 32'hFFFF_FF8A, 4'hF);
        expect_slot(23, "sb lane 0", 32'h0000_005A, 4'b0001);
        expect_slot(24, "sb lane 1", 32'h0000_5A00, 4'b0010);
        expect_slot(25, "sb lane 2", 32'h005A_0000, 4'b0100);
        expect_slot(26, "sb lane 3", 32'h5A00_0000, 4'b1000);
        expect_slot(27, "sh lower", 32'h0000_FFF9, 4'b0011);
        expect_slot(28, "sh upper", 32'hFFF9_0000, 4'b1100);
    end

    assign wr_done   = psel && penable && pready && pwrite;
    assign result_wr = wr_done && (paddr >= result_base) &&
                       (paddr < result_base + 4 * n_results);
    assign slot      = int'((paddr - result_base) >> 2);

    always @(posedge clk_in) begin
        if (!reset_in) begin
            written <= '0;
        end else if (result_wr) begin
            written[slot] <= 1'b1;
        end
    end

    psel_low_in_reset: assert property (@(posedge clk_in) !reset_in |=> !psel)
        else begin
            $error("psel high during reset");
            record("psel high during reset", '0, '0, 1'b0);
        end

    enable_after_setup: assert property (@(posedge clk_in) disable iff (!reset_in)
        $rose(penable) |-> $past(psel && !penable))
        else begin
            $error("penable rose without a setup cycle");
            record("penable rose without a setup cycle", '0, '0, 1'b0);
        end

    setup_then_access: assert property (@(posedge clk_in) disable iff (!reset_in)
        (psel && !penable) |=> (psel && penable))
        else begin
            $error("setup cycle not followed by access");
            record("setup cycle not followed by access", '0, '0, 1'b0);
        end

    hold_while_waiting: assert property (@(posedge clk_in) disable iff (!reset_in)
        (penable && !pready) |=> (penable && $stable(paddr) && $stable(pwrite) &&
                                  $stable(pwdata) && $stable(pstrb)))
        else begin
            $error("APB request changed during wait state");
            record("APB request changed during a wait state", '0, '0, 1'b0);
        end

    word_aligned: assert property (@(posedge clk_in) disable iff (!reset_in)
        psel |-> (paddr[1:0] == 2'b00))
        else begin
            $error("paddr not word aligned");
            record("paddr not word aligned", '0, '0, 1'b0);
        end

    result_data: assert property (@(posedge clk_in) disable iff (!reset_in)
        result_wr |-> (pwdata == exp_data[slot]))
        else begin
            $error("result data mismatch");
            record(names[$sampled(slot)], exp_data[$sampled(slot)], $sampled(pwdata), 1'b1);
        end

    result_strobe: assert property (@(posedge clk_in) disable iff (!reset_in)
        result_wr |-> (pstrb == exp_strb[slot]))
        else begin
            $error("result strobe mismatch");
            record({names[$sampled(slot)], " strobe"}, word_t'(exp_strb[$sampled(slot)]),
                   word_t'($sampled(pstrb)), 1'b1);
        end

    // Every result slot must be written before the done store
    all_results_seen: assert property (@(posedge clk_in) disable iff (!reset_in)
        (wr_done && paddr == done_addr) |-> (&written))
        else begin
            $error("done store before all results");
            record("program finished before storing every result", '0, '0, 1'b0);
        end

endmodule

bind rv_core rv_core_props u_props (.*);

/* hw/rv_core.sv */
module rv_core
    import rv_core_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset_in,
    output word_t      paddr,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output word_t      pwdata,
    output logic [3:0] pstrb,
    input  word_t      prdata,
    input  logic       pready
);

    word_t       instruction;
    opcode_t     opcode;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       imm;
    logic        use_imm;
    alu_op_t     alu_op;
    branch_t     branch_kind;
    mem_size_t   mem_size;
    mem_size_t   bus_size;
    logic        load_unsigned;
    logic        writes_rd;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       alu_b;
    word_t       alu_result;
    logic        branch_taken;
    logic        rf_we;
    word_t       rf_wdata;
    logic        bus_start;
    logic        bus_write;
    word_t       bus_addr;
    logic        bus_done;
    word_t       load_data;

    assign alu_b = use_imm ? imm : rs2_data;

    rv_decoder u_decoder (
        .instruction   (instruction),
        .opcode        (opcode),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .imm           (imm),
        .use_imm       (use_imm),
        .alu_op        (alu_op),
        .branch_kind   (branch_kind),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .writes_rd     (writes_rd)
    );

    rv_regfile u_regfile (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .rs1      (rs1),
        .rs2      (rs2),
        .we       (rf_we),
        .rd       (rd),
        .wdata    (rf_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .a            (rs1_data),
        .b            (alu_b),
        .alu_op       (alu_op),
        .branch_kind  (branch_kind),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv_bus_unit u_bus_unit (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .start         (bus_start),
        .write         (bus_write),
        .addr          (bus_addr),
        .size          (bus_size),
        .load_unsigned (load_unsigned),
        .store_data    (rs2_data),
        .prdata        (prdata),
        .pready        (pready),
        .done          (bus_done),
        .load_data     (load_data),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .pstrb         (pstrb)
    );

    rv_control u_control (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .opcode       (opcode),
        .imm          (imm),
        .writes_rd    (writes_rd),
        .mem_size     (mem_size),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .done         (bus_done),
        .load_data    (load_data),
        .instruction  (instruction),
        .pc           (),
        .start        (bus_start),
        .write        (bus_write),
        .bus_addr     (bus_addr),
        .size         (bus_size),
        .rf_we        (rf_we),
        .rf_wdata     (rf_wdata),
        .state        ()
    );

endmodule

/* hw/rv_control.sv */
module rv_control
    import rv_core_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset_in,
    input  opcode_t     opcode,
    input  word_t       imm,
    input  logic        writes_rd,
    input  mem_size_t   mem_size,
    input  word_t       alu_result,
    input  logic        branch_taken,
    input  logic        done,
    input  word_t       load_data,
    output word_t       instruction,
    output word_t       pc,
    output logic        start,
    output logic        write,
    output word_t       bus_addr,
    output mem_size_t   size,
    output logic        rf_we,
    output word_t       rf_wdata,
    output ctrl_state_t state
);

    word_t pc_plus4;
    word_t pc_plus_imm;
    word_t next_pc;
    logic  is_mem;

    assign pc_plus4    = pc + 32'd4;
    assign pc_plus_imm = pc + imm;
    assign is_mem      = (opcode == OP_LOAD) || (opcode == OP_STORE);

    always_comb begin
        case (opcode)
            OP_JAL:    next_pc = pc_plus_imm;
            OP_JALR:   next_pc = {alu_result[xlen-1:1], 1'b0};
            OP_BRANCH: next_pc = branch_taken ? pc_plus_imm : pc_plus4;
            default:   next_pc = pc_plus4;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_LUI:          rf_wdata = imm;
            OP_AUIPC:        rf_wdata = pc_plus_imm;
            OP_JAL, OP_JALR: rf_wdata = pc_plus4;
            OP_LOAD:         rf_wdata = load_data;
            default:         rf_wdata = alu_result;
        endcase
    end

    // Loads write back when their data arrives, everything else in execute
    assign rf_we = ((state == CTRL_EXECUTE) && writes_rd && !is_mem) ||
                   ((state == CTRL_WAIT_MEM) && writes_rd && done);

    // Fetch uses the pc, data accesses the ALU sum
    assign start    = (state == CTRL_FETCH) || ((state == CTRL_EXECUTE) && is_mem);
    assign write    = (state == CTRL_EXECUTE) && (opcode == OP_STORE);
    assign bus_addr = (state == CTRL_FETCH) ? pc : alu_result;
    assign size     = (state == CTRL_FETCH) ? MEM_WORD : mem_size;

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            state <= CTRL_FETCH;
            pc    <= reset_pc;
        end else begin
            case (state)
                CTRL_FETCH: state <= CTRL_WAIT_FETCH;
                CTRL_WAIT_FETCH: begin
                    if (done) begin
                        state <= CTRL_EXECUTE;
                    end
                end
                CTRL_EXECUTE: begin
                    pc    <= next_pc;
                    state <= is_mem ? CTRL_WAIT_MEM : CTRL_FETCH;
                end
                CTRL_WAIT_MEM: begin
                    if (done) begin
                        state <= CTRL_FETCH;
                    end
                end
                default: state <= CTRL_FETCH;
            endcase
        end
    end

    // Instruction latch
    always_ff @(posedge clk_in) begin
        if (state == CTRL_WAIT_FETCH && done) begin
            instruction <= load_data;
        end
    end

endmodule

/* hw/rv_bus_unit.sv */
module rv_bus_unit
    import rv_core_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset_in,
    input  logic       start,
    input  logic       write,
    input  word_t      addr,
    input  mem_size_t  size,
    input  logic       load_unsigned,
    input  word_t      store_data,
    input  word_t      prdata,
    input  logic       pready,
    output logic       done,
    output word_t      load_data,
    output word_t      paddr,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output word_t      pwdata,
    output logic [3:0] pstrb
);

    bus_state_t state;
    mem_size_t  size_q;
    logic [1:0] offset_q;
    logic       unsigned_q;
    word_t      lane_data;
    logic [3:0] lane_strb;
    word_t      rd_shifted;

    // Move the store value onto its byte lanes
    always_comb begin
        case (size)
            MEM_BYTE: begin
                lane_data = {24'b0, store_data[7:0]} << {addr[1:0], 3'b000};
                lane_strb = 4'b0001 << addr[1:0];
            end
            MEM_HALF: begin
                lane_data = {16'b0, store_data[15:0]} << {addr[1], 4'b0000};
                lane_strb = 4'b0011 << {addr[1], 1'b0};
            end
            default: begin
                lane_data = store_data;
                lane_strb = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            state  <= BUS_IDLE;
            pwrite <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (start) begin
                        state  <= BUS_SETUP;
                        pwrite <= write;
                    end
                end
                BUS_SETUP: state <= BUS_ACCESS;
                BUS_ACCESS: begin
                    // Wait states from the memory just hold us here
                    if (pready) begin
                        state <= BUS_IDLE;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // Request payload, held for the whole transfer
    always_ff @(posedge clk_in) begin
        if (state == BUS_IDLE && start) begin
            paddr      <= {addr[xlen-1:2], 2'b00};
            pwdata     <= lane_data;
            pstrb      <= write ? lane_strb : 4'b0000;
            size_q     <= size;
            offset_q   <= addr[1:0];
            unsigned_q <= load_unsigned;
        end
    end

    assign psel    = (state != BUS_IDLE);
    assign penable = (state == BUS_ACCESS);
    assign done    = penable && pready;

    // Pull the addressed lane down and extend from its own top bit
    always_comb begin
        case (size_q)
            MEM_BYTE: begin
                rd_shifted = prdata >> {offset_q, 3'b000};
                load_data  = {{24{!unsigned_q && rd_shifted[7]}}, rd_shifted[7:0]};
            end
            MEM_HALF: begin
                rd_shifted = prdata >> {offset_q[1], 4'b0000};
                load_data  = {{16{!unsigned_q && rd_shifted[15]}}, rd_shifted[15:0]};
            end
            default: begin
                rd_shifted = prdata;
                load_data  = rd_shifted;
            end
        endcase
    end

endmodule

/* hw/rv_alu.sv */
module rv_alu
    import rv_core_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t alu_op,
    input  branch_t branch_kind,
    output word_t   result,
    output logic    branch_taken
);

    logic [xlen:0] diff_ext;
    word_t         diff;
    logic          borrow;
    logic          zero;
    logic          overflow;
    logic          lt_signed;
    logic [4:0]    shamt;

    // One subtractor feeds sub, slt, sltu and every branch compare
    assign diff_ext  = {1'b0, a} - {1'b0, b};
    assign diff      = diff_ext[xlen-1:0];
    assign borrow    = diff_ext[xlen];
    assign zero      = (diff == '0);
    assign overflow  = (a[xlen-1] ^ b[xlen-1]) & (a[xlen-1] ^ diff[xlen-1]);
    assign lt_signed = diff[xlen-1] ^ overflow;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_SUB:  result = diff;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(xlen-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(xlen-1){1'b0}}, borrow};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

    always_comb begin
        case (branch_kind)
            BR_EQ:   branch_taken = zero;
            BR_NE:   branch_taken = !zero;
            BR_LT:   branch_taken = lt_signed;
            BR_GE:   branch_taken = !lt_signed;
            BR_LTU:  branch_taken = borrow;
            BR_GEU:  branch_taken = !borrow;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* hw/rv_regfile.sv */
module rv_regfile
    import rv_core_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset_in,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wdata,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [32];

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* hw/rv_decoder.sv */
module rv_decoder
    import rv_core_pkg::*;
(
    input  word_t      instruction,
    output opcode_t    opcode,
    output reg_addr_t  rd,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output word_t      imm,
    output logic       use_imm,
    output alu_op_t    alu_op,
    output branch_t    branch_kind,
    output mem_size_t  mem_size,
    output logic       load_unsigned,
    output logic       writes_rd
);

    logic [2:0] funct3;
    logic       alt;
    logic       is_shift;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign rd     = instruction[11:7];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign funct3 = instruction[14:12];
    assign alt    = instruction[30];

    always_comb begin
        case (instruction[6:0])
            7'b0110011: opcode = OP_ARITH_R;
            7'b0010011: opcode = OP_ARITH_I;
            7'b1100011: opcode = OP_BRANCH;
            7'b1101111: opcode = OP_JAL;
            7'b1100111: opcode = OP_JALR;
            7'b0000011: opcode = OP_LOAD;
            7'b0100011: opcode = OP_STORE;
            7'b0110111: opcode = OP_LUI;
            7'b0010111: opcode = OP_AUIPC;
            default:    opcode = OP_OTHER;
        endcase
    end

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'h000};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    assign is_shift = (opcode == OP_ARITH_I) && (funct3[1:0] == 2'b01);

    always_comb begin
        case (opcode)
            OP_STORE:          imm = imm_s;
            OP_BRANCH:         imm = imm_b;
            OP_LUI, OP_AUIPC:  imm = imm_u;
            OP_JAL:            imm = imm_j;
            default:           imm = is_shift ? {27'b0, instruction[24:20]} : imm_i;
        endcase
    end

    assign use_imm = (opcode == OP_ARITH_I) || (opcode == OP_LOAD) ||
                     (opcode == OP_STORE) || (opcode == OP_JALR);

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == OP_ARITH_R && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        // Address and jump target arithmetic is always a plain add
        if (opcode != OP_ARITH_R && opcode != OP_ARITH_I) begin
            alu_op = ALU_ADD;
        end
    end

    always_comb begin
        case (funct3)
            3'b001:  branch_kind = BR_NE;
            3'b100:  branch_kind = BR_LT;
            3'b101:  branch_kind = BR_GE;
            3'b110:  branch_kind = BR_LTU;
            3'b111:  branch_kind = BR_GEU;
            default: branch_kind = BR_EQ;
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   mem_size = MEM_BYTE;
            2'b01:   mem_size = MEM_HALF;
            default: mem_size = MEM_WORD;
        endcase
    end

    assign load_unsigned = funct3[2];

    assign writes_rd = (opcode != OP_BRANCH) && (opcode != OP_STORE) &&
                       (opcode != OP_OTHER) && (rd != 5'd0);

endmodule

/* hw/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // First fetch address after reset
    localparam word_t reset_pc = 32'h0000_0000;

    // Major opcodes, SYSTEM and anything unknown collapse to OP_OTHER
    typedef enum logic [6:0] {
        OP_ARITH_R = 7'b0110011,
        OP_ARITH_I = 7'b0010011,
        OP_BRANCH  = 7'b1100011,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_OTHER   = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Encoded as the branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    typedef enum logic [3:0] {
        CTRL_FETCH      = 4'b0001,
        CTRL_WAIT_FETCH = 4'b0010,
        CTRL_EXECUTE    = 4'b0100,
        CTRL_WAIT_MEM   = 4'b1000
    } ctrl_state_t;

    typedef enum logic [1:0] {
        BUS_IDLE   = 2'b00,
        BUS_SETUP  = 2'b01,
        BUS_ACCESS = 2'b10
    } bus_state_t;

endpackage
